// File: hdl/quad_pkg.sv
package quad_pkg;

    //////////////////////////////
    // Datapath sizes
    //////////////////////////////

    // Compute-engine lanes per pixel word
    parameter int NUM_LANES      = 8;
    parameter int PIXEL_WIDTH    = 16;

    // Default depths, overridden from the top level
    parameter int ROW_DEPTH_DEF  = 512;
    parameter int FIFO_DEPTH_DEF = 16;

    // Sequence memory, 128-bit words
    parameter int SEQ_WORDS      = 512;
    // Lane select bits in a sequence address
    parameter int SEQ_LANE_BITS  = $clog2(NUM_LANES);

    //////////////////////////////
    // Types
    //////////////////////////////

    // One word across all lanes, lane 0 in the low bits
    typedef logic [NUM_LANES-1:0][PIXEL_WIDTH-1:0] pixel_word_t;

    typedef logic [8:0]  col_t;

    // Word index in [11:3], lane in [2:0]
    typedef logic [11:0] seq_addr_t;

    // One 16-bit sequence entry
    typedef struct packed {
        logic [6:0] reserved;
        col_t       col;
    } seq_entry_t;

    // Per-job settings from the main state machine
    typedef struct packed {
        col_t      num_cols;
        seq_addr_t seq_len;
    } job_params_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_REQ,
        ST_FETCH,
        ST_LOAD_DRAIN,
        ST_EMIT,
        ST_JOB_DONE
    } ctrl_state_t;

endpackage

// File: hdl/pixel_seq_store.sv
`timescale 1ns/100ps

module pixel_seq_store (
    input  logic                   clk_if,
    input  logic                   rst,
    input  logic                   config_valid,
    output logic                   config_accept,
    input  quad_pkg::pixel_word_t  config_data,
    input  logic                   seq_rd_en,
    input  quad_pkg::seq_addr_t    seq_rd_addr,
    output quad_pkg::seq_entry_t   seq_entry
);

    localparam int WA = $clog2(quad_pkg::SEQ_WORDS);
    localparam int LB = quad_pkg::SEQ_LANE_BITS;

    // Wide write port, eight entries per word
    quad_pkg::pixel_word_t mem [quad_pkg::SEQ_WORDS];

    logic [WA-1:0] wr_addr;
    logic          cfg_wr;

    // Word index and lane select from the read address
    logic [WA-1:0] rd_word;
    logic [LB-1:0] rd_lane;

    assign cfg_wr  = config_valid && config_accept;
    assign rd_word = seq_rd_addr[LB +: WA];
    assign rd_lane = seq_rd_addr[LB-1:0];

    //////////////////////////////
    // Config handshake
    //////////////////////////////

    // Accept trails valid by one cycle
    // Write pointer wraps at the memory end
    always_ff @(posedge clk_if) begin
        if (rst) begin
            config_accept <= 1'b0;
            wr_addr       <= '0;
        end else begin
            config_accept <= config_valid;
            if (cfg_wr) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Memory
    //////////////////////////////

    always_ff @(posedge clk_if) begin
        if (cfg_wr) begin
            mem[wr_addr] <= config_data;
        end
        // Narrow read, one lane of the addressed word
        // Output holds between reads
        if (seq_rd_en) begin
            seq_entry <= quad_pkg::seq_entry_t'(mem[rd_word][rd_lane]);
        end
    end

endmodule

// File: hdl/prefetch_fifo.sv
`timescale 1ns/100ps

module prefetch_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   clk_if,
    input  logic                   rst,
    input  logic                   fetch_active,
    input  logic                   pixel_valid,
    output logic                   pixel_ready,
    input  quad_pkg::pixel_word_t  pixel_data,
    input  logic                   fifo_pop,
    output quad_pkg::pixel_word_t  fifo_data,
    output logic                   fifo_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    quad_pkg::pixel_word_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          push;
    logic          pop;

    assign full       = count == CW'(FIFO_DEPTH);
    assign fifo_empty = count == '0;

    // Pixel port open only during a fetch, closed when full
    assign pixel_ready = pixel_valid && fetch_active && !full;
    assign push        = pixel_valid && pixel_ready;
    assign pop         = fifo_pop && !fifo_empty;

    // Show-ahead, head word visible before the pop
    assign fifo_data = mem[rd_ptr];

    always_ff @(posedge clk_if) begin
        if (push) begin
            mem[wr_ptr] <= pixel_data;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk_if) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/quad_ctrl.sv
`timescale 1ns/100ps

module quad_ctrl (
    input  logic                   clk_if,
    input  logic                   rst,
    input  logic                   job_start,
    output logic                   job_accept,
    input  quad_pkg::job_params_t  job_parameters,
    output logic                   job_fetch_request,
    input  logic                   job_fetch_ack,
    input  logic                   job_fetch_complete,
    output logic                   job_complete,
    input  logic                   job_complete_ack,
    output logic                   fetch_active,
    output logic                   fifo_pop,
    input  logic                   fifo_empty,
    output logic                   row_wr_en,
    output quad_pkg::col_t         row_wr_col,
    output logic                   seq_rd_en,
    output quad_pkg::seq_addr_t    seq_rd_addr,
    input  quad_pkg::seq_entry_t   seq_entry,
    output logic                   row_rd_en,
    output quad_pkg::col_t         row_rd_col,
    input  logic                   row_rd_ready,
    input  logic                   results_drained
);

    quad_pkg::ctrl_state_t state;
    quad_pkg::job_params_t params_q;

    // Next column to load
    quad_pkg::col_t        wr_col;
    // Next sequence entry to read
    quad_pkg::seq_addr_t   issue_idx;

    // Entry on seq_entry not yet turned into a row read
    logic entry_pending;
    logic walk_done;
    logic loading;

    //////////////////////////////
    // Row load
    //////////////////////////////

    assign fetch_active = state == quad_pkg::ST_FETCH;
    assign job_complete = state == quad_pkg::ST_JOB_DONE;

    // Drain the FIFO during and after the fetch
    assign loading  = (state == quad_pkg::ST_FETCH) || (state == quad_pkg::ST_LOAD_DRAIN);
    assign fifo_pop = loading && !fifo_empty;

    // Beats past num_cols are popped and dropped
    assign row_wr_en  = fifo_pop && (wr_col < params_q.num_cols);
    assign row_wr_col = wr_col;

    //////////////////////////////
    // Sequence walk
    //////////////////////////////

    // Row read as soon as the output queue has room
    assign row_rd_en  = entry_pending && row_rd_ready;
    assign row_rd_col = seq_entry.col;

    // At most one entry fetched ahead of its row read
    assign seq_rd_en = (state == quad_pkg::ST_EMIT)
                       && (issue_idx < params_q.seq_len)
                       && (!entry_pending || row_rd_en);
    assign seq_rd_addr = issue_idx;

    assign walk_done = (issue_idx == params_q.seq_len) && !entry_pending;

    // Job settings, captured with the accept
    always_ff @(posedge clk_if) begin
        if ((state == quad_pkg::ST_IDLE) && job_start) begin
            params_q <= job_parameters;
        end
    end

    //////////////////////////////
    // Job FSM
    //////////////////////////////

    always_ff @(posedge clk_if) begin
        if (rst) begin
            state             <= quad_pkg::ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            entry_pending     <= 1'b0;
            wr_col            <= '0;
            issue_idx         <= '0;
        end else begin
            // One-cycle accept pulse
            job_accept <= 1'b0;

            if (seq_rd_en) begin
                entry_pending <= 1'b1;
            end else if (row_rd_en) begin
                entry_pending <= 1'b0;
            end
            if (seq_rd_en) begin
                issue_idx <= issue_idx + 1'b1;
            end
            if (row_wr_en) begin
                wr_col <= wr_col + 1'b1;
            end

            case (state)
                quad_pkg::ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        wr_col     <= '0;
                        issue_idx  <= '0;
                        state      <= quad_pkg::ST_FETCH_REQ;
                    end
                end
                quad_pkg::ST_FETCH_REQ: begin
                    // Request rises the cycle after accept
                    job_fetch_request <= 1'b1;
                    if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        state             <= quad_pkg::ST_FETCH;
                    end
                end
                quad_pkg::ST_FETCH: begin
                    if (job_fetch_complete) begin
                        state <= quad_pkg::ST_LOAD_DRAIN;
                    end
                end
                quad_pkg::ST_LOAD_DRAIN: begin
                    if (fifo_empty) begin
                        state <= quad_pkg::ST_EMIT;
                    end
                end
                quad_pkg::ST_EMIT: begin
                    // Wait until every result has left the queue
                    if (walk_done && results_drained) begin
                        state <= quad_pkg::ST_JOB_DONE;
                    end
                end
                quad_pkg::ST_JOB_DONE: begin
                    if (job_complete_ack) begin
                        state <= quad_pkg::ST_IDLE;
                    end
                end
                default: state <= quad_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/row_buffer.sv
`timescale 1ns/100ps

module row_buffer #(
    parameter int ROW_DEPTH = 512
) (
    input  logic                   clk_if,
    input  logic                   rst,
    input  logic                   row_wr_en,
    input  quad_pkg::col_t         row_wr_col,
    input  quad_pkg::pixel_word_t  row_wr_data,
    input  logic                   row_rd_en,
    input  quad_pkg::col_t         row_rd_col,
    output logic                   row_rd_ready,
    output logic                   results_drained,
    output logic                   result_valid,
    input  logic                   result_accept,
    output quad_pkg::pixel_word_t  result_data
);

    // One pixel word per input column
    quad_pkg::pixel_word_t mem [ROW_DEPTH];

    // Registered read data and its valid flag
    quad_pkg::pixel_word_t rd_data;
    logic                  rd_inflight;

    // Two-entry output queue
    quad_pkg::pixel_word_t q_data [2];
    logic                  q_wr_ptr;
    logic                  q_rd_ptr;
    logic [1:0]            q_count;
    logic                  q_pop;

    always_ff @(posedge clk_if) begin
        if (row_wr_en) begin
            mem[row_wr_col] <= row_wr_data;
        end
        if (row_rd_en) begin
            rd_data <= mem[row_rd_col];
        end
        if (rd_inflight) begin
            q_data[q_wr_ptr] <= rd_data;
        end
    end

    //////////////////////////////
    // Result port
    //////////////////////////////

    assign result_valid = q_count != 2'd0;
    assign result_data  = q_data[q_rd_ptr];
    assign q_pop        = result_valid && result_accept;

    // Queue entries plus the read in flight, a pop frees a slot
    assign row_rd_ready    = ((q_count + 2'(rd_inflight)) < 2'd2) || q_pop;
    assign results_drained = (q_count == 2'd0) && !rd_inflight;

    always_ff @(posedge clk_if) begin
        if (rst) begin
            rd_inflight <= 1'b0;
            q_wr_ptr    <= 1'b0;
            q_rd_ptr    <= 1'b0;
            q_count     <= 2'd0;
        end else begin
            rd_inflight <= row_rd_en;
            if (rd_inflight) begin
                q_wr_ptr <= !q_wr_ptr;
            end
            if (q_pop) begin
                q_rd_ptr <= !q_rd_ptr;
            end
            case ({rd_inflight, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

endmodule

// File: hdl/cnn_quad_top.sv
`timescale 1ns/100ps

module cnn_quad_top #(
    parameter int ROW_DEPTH  = quad_pkg::ROW_DEPTH_DEF,
    parameter int FIFO_DEPTH = quad_pkg::FIFO_DEPTH_DEF
) (
    input  logic                   clk_if,
    input  logic                   rst,

    // Job handshake with the main state machine
    input  logic                   job_start,
    output logic                   job_accept,
    input  quad_pkg::job_params_t  job_parameters,
    output logic                   job_fetch_request,
    input  logic                   job_fetch_ack,
    input  logic                   job_fetch_complete,
    output logic                   job_complete,
    input  logic                   job_complete_ack,

    input  logic                   config_valid,
    output logic                   config_accept,
    input  quad_pkg::pixel_word_t  config_data,

    input  logic                   pixel_valid,
    output logic                   pixel_ready,
    input  quad_pkg::pixel_word_t  pixel_data,

    output logic                   result_valid,
    input  logic                   result_accept,
    output quad_pkg::pixel_word_t  result_data
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    logic                  fetch_active;
    logic                  fifo_pop;
    logic                  fifo_empty;
    quad_pkg::pixel_word_t fifo_data;

    logic                  row_wr_en;
    quad_pkg::col_t        row_wr_col;
    logic                  row_rd_en;
    quad_pkg::col_t        row_rd_col;
    logic                  row_rd_ready;
    logic                  results_drained;

    logic                  seq_rd_en;
    quad_pkg::seq_addr_t   seq_rd_addr;
    quad_pkg::seq_entry_t  seq_entry;

    // Sequence memory, loaded over the config port
    pixel_seq_store i_seq_store (
        .clk_if, .rst, .config_valid, .config_accept, .config_data,
        .seq_rd_en, .seq_rd_addr, .seq_entry
    );

    prefetch_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_prefetch_fifo (
        .clk_if, .rst, .fetch_active, .pixel_valid, .pixel_ready, .pixel_data,
        .fifo_pop, .fifo_data, .fifo_empty
    );

    quad_ctrl i_ctrl (
        .clk_if, .rst, .job_start, .job_accept, .job_parameters,
        .job_fetch_request, .job_fetch_ack, .job_fetch_complete,
        .job_complete, .job_complete_ack, .fetch_active,
        .fifo_pop, .fifo_empty, .row_wr_en, .row_wr_col,
        .seq_rd_en, .seq_rd_addr, .seq_entry,
        .row_rd_en, .row_rd_col, .row_rd_ready, .results_drained
    );

    // FIFO head goes straight into the row memory
    row_buffer #(.ROW_DEPTH(ROW_DEPTH)) i_row_buffer (
        .clk_if, .rst, .row_wr_en, .row_wr_col, .row_wr_data(fifo_data),
        .row_rd_en, .row_rd_col, .row_rd_ready, .results_drained,
        .result_valid, .result_accept, .result_data
    );

endmodule

// File: verif/quad_checker.sv
`timescale 1ns/100ps

module quad_checker (
    input  logic                   clk_if,
    input  logic                   rst,
    input  logic                   job_accept,
    input  logic                   job_fetch_request,
    input  logic                   job_fetch_ack,
    input  logic                   job_fetch_complete,
    input  logic                   job_complete,
    input  logic                   job_complete_ack,
    input  logic                   config_valid,
    input  logic                   config_accept,
    input  logic                   pixel_valid,
    input  logic                   pixel_ready,
    input  logic                   result_valid,
    input  logic                   result_accept,
    input  quad_pkg::pixel_word_t  result_data
);

    int error_count = 0;
    int beat_count  = 0;

    quad_pkg::pixel_word_t exp_q [$];
    quad_pkg::pixel_word_t exp_word;
    quad_pkg::pixel_word_t prev_data;

    // Window from fetch ack to fetch complete
    logic fetch_open;
    logic accepted;
    logic prev_valid;
    logic prev_accept;
    logic prev_complete;
    logic prev_ack;
    logic prev_request;
    logic prev_cfg_valid;

    task automatic push_expected(input quad_pkg::pixel_word_t w);
        exp_q.push_back(w);
    endtask

    task automatic check_low(input string name, input logic v);
        if (v !== 1'b0) begin
            error_count++;
            $display("Fail %s: expected %h got %h", name, 1'b0, v);
        end
    endtask

    task automatic check_reset_outputs();
        check_low("job_accept", job_accept);
        check_low("job_fetch_request", job_fetch_request);
        check_low("job_complete", job_complete);
        check_low("config_accept", config_accept);
        check_low("pixel_ready", pixel_ready);
        check_low("result_valid", result_valid);
    endtask

    //////////////////////////////
    // Port monitor
    //////////////////////////////

    always @(posedge clk_if) begin
        if (rst) begin
            fetch_open     <= 1'b0;
            accepted       <= 1'b0;
            prev_valid     <= 1'b0;
            prev_accept    <= 1'b0;
            prev_complete  <= 1'b0;
            prev_ack       <= 1'b0;
            prev_request   <= 1'b0;
            prev_cfg_valid <= 1'b0;
        end else begin
            // Config accept follows valid one cycle later
            if (config_accept !== prev_cfg_valid) begin
                error_count++;
                $display("Fail config_accept: expected %h got %h",
                         prev_cfg_valid, config_accept);
            end

            if (pixel_valid && pixel_ready) begin
                beat_count++;
                if (!fetch_open) begin
                    error_count++;
                    $display("Pixel beat taken outside the fetch window");
                end
            end
            if (job_fetch_request && job_fetch_ack) fetch_open <= 1'b1;
            if (job_fetch_complete) fetch_open <= 1'b0;

            // Accept must precede the fetch request
            if (job_accept) accepted <= 1'b1;
            if (job_fetch_request && !prev_request && !accepted) begin
                error_count++;
                $display("job_fetch_request rose before job_accept");
            end
            if (job_complete && job_complete_ack) accepted <= 1'b0;

            if (job_complete && !prev_complete && exp_q.size() != 0) begin
                error_count++;
                $display("job_complete rose with %0d results still missing", exp_q.size());
            end
            if (!job_complete && prev_complete && !prev_ack) begin
                error_count++;
                $display("job_complete fell without job_complete_ack");
            end

            // Stalled data must hold
            if (prev_valid && !prev_accept) begin
                if (!result_valid) begin
                    error_count++;
                    $display("result_valid dropped while the result was stalled");
                end else if (result_data !== prev_data) begin
                    error_count++;
                    $display("Fail result_data: expected %h got %h", prev_data, result_data);
                end
            end

            if (result_valid && result_accept) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Result accepted with no expected word left");
                end else begin
                    exp_word = exp_q.pop_front();
                    if (result_data !== exp_word) begin
                        error_count++;
                        $display("Fail result_data: expected %h got %h",
                                 exp_word, result_data);
                    end
                end
            end

            prev_valid     <= result_valid;
            prev_accept    <= result_accept;
            prev_data      <= result_data;
            prev_complete  <= job_complete;
            prev_ack       <= job_complete_ack;
            prev_request   <= job_fetch_request;
            prev_cfg_valid <= config_valid;
        end
    end

endmodule

// File: verif/tb_quad.sv
`timescale 1ns/100ps

module tb_quad;

    localparam int TIMEOUT   = 2000;
    localparam int TRACE_LEN = 128;

    logic                  clk_if;
    logic                  rst;
    logic                  job_start;
    logic                  job_accept;
    quad_pkg::job_params_t job_parameters;
    logic                  job_fetch_request;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  config_valid;
    logic                  config_accept;
    quad_pkg::pixel_word_t config_data;
    logic                  pixel_valid;
    logic                  pixel_ready;
    quad_pkg::pixel_word_t pixel_data;
    logic                  result_valid;
    logic                  result_accept;
    quad_pkg::pixel_word_t result_data;

    // Tag byte above a 128-bit payload
    logic [135:0] trace_mem [TRACE_LEN];
    int           ti;
    logic         stall_mode;
    logic         trace_bad;
    int           tests_run;
    int           tests_failed;
    int           err_before;
    int           job_num;

    initial clk_if = 1'b0;
    always #4 clk_if = ~clk_if;

    cnn_quad_top #(.ROW_DEPTH(512), .FIFO_DEPTH(16)) i_dut (
        .clk_if, .rst, .job_start, .job_accept, .job_parameters,
        .job_fetch_request, .job_fetch_ack, .job_fetch_complete,
        .job_complete, .job_complete_ack, .config_valid, .config_accept,
        .config_data, .pixel_valid, .pixel_ready, .pixel_data,
        .result_valid, .result_accept, .result_data
    );

    quad_checker i_chk (
        .clk_if, .rst, .job_accept, .job_fetch_request, .job_fetch_ack,
        .job_fetch_complete, .job_complete, .job_complete_ack, .config_valid,
        .config_accept, .pixel_valid, .pixel_ready, .result_valid, .result_accept,
        .result_data
    );

    // Random result back-pressure in stall jobs only
    initial begin
        void'($urandom(97));
        forever begin
            @(negedge clk_if);
            if (stall_mode) begin
                result_accept = ($urandom % 3) != 0;
            end else begin
                result_accept = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Something failed");
        $finish;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (i_chk.error_count != err_before) begin
            tests_failed++;
            $display("Test %0d %s: fail", tests_run, name);
        end else begin
            $display("Test %0d %s: pass", tests_run, name);
        end
        err_before = i_chk.error_count;
    endtask

    // Hold valid until accept shows
    // Write lands on the next edge
    task automatic send_config(input quad_pkg::pixel_word_t w);
        int t;
        config_valid = 1'b1;
        config_data  = w;
        t = 0;
        while (!config_accept) begin
            @(negedge clk_if);
            t++;
            if (t > TIMEOUT) timed_out("config_accept");
        end
        @(negedge clk_if);
    endtask

    task automatic run_job();
        quad_pkg::job_params_t params;
        quad_pkg::pixel_word_t beats [$];
        logic                  stall;
        int                    base;
        int                    t;
        params = trace_mem[ti][20:0];
        stall  = trace_mem[ti][32];
        ti++;
        // Collect the beats and queue the expected words
        while (ti < TRACE_LEN && (trace_mem[ti][135:128] == 8'h03
               || trace_mem[ti][135:128] == 8'h04)) begin
            if (trace_mem[ti][135:128] == 8'h03) begin
                beats.push_back(trace_mem[ti][127:0]);
            end else begin
                i_chk.push_expected(trace_mem[ti][127:0]);
            end
            ti++;
        end
        stall_mode     = stall;
        job_start      = 1'b1;
        job_parameters = params;
        t = 0;
        while (!job_accept) begin
            @(negedge clk_if);
            t++;
            if (t > TIMEOUT) timed_out("job_accept");
        end
        job_start = 1'b0;
        // First beat offered early while the port is still shut
        pixel_valid = 1'b1;
        pixel_data  = beats[0];
        t = 0;
        while (!job_fetch_request) begin
            @(negedge clk_if);
            t++;
            if (t > TIMEOUT) timed_out("job_fetch_request");
        end
        repeat (2) @(negedge clk_if);
        job_fetch_ack = 1'b1;
        @(negedge clk_if);
        job_fetch_ack = 1'b0;
        base = i_chk.beat_count;
        for (int k = 0; k < beats.size(); k++) begin
            pixel_data = beats[k];
            t = 0;
            while (i_chk.beat_count < base + k + 1) begin
                @(negedge clk_if);
                t++;
                if (t > TIMEOUT) timed_out("pixel_ready");
            end
        end
        pixel_valid        = 1'b0;
        job_fetch_complete = 1'b1;
        @(negedge clk_if);
        job_fetch_complete = 1'b0;
        // Stray beats after the fetch must be refused
        pixel_valid = 1'b1;
        pixel_data  = {quad_pkg::NUM_LANES{16'hdead}};
        repeat (3) @(negedge clk_if);
        pixel_valid = 1'b0;
        t = 0;
        while (!job_complete) begin
            @(negedge clk_if);
            t++;
            if (t > TIMEOUT) timed_out("job_complete");
        end
        job_complete_ack = 1'b1;
        t = 0;
        while (job_complete) begin
            @(negedge clk_if);
            t++;
            if (t > TIMEOUT) timed_out("job_complete to fall");
        end
        job_complete_ack = 1'b0;
        stall_mode       = 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst                = 1'b1;
        job_start          = 1'b0;
        job_parameters     = '0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        config_valid       = 1'b0;
        config_data        = '0;
        pixel_valid        = 1'b0;
        pixel_data         = '0;
        result_accept      = 1'b0;
        stall_mode         = 1'b0;
        trace_bad          = 1'b0;
        tests_run          = 0;
        tests_failed       = 0;
        err_before         = 0;
        job_num            = 0;
        $readmemh("verif/quad_trace.txt", trace_mem);
        repeat (4) @(posedge clk_if);
        @(negedge clk_if);
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk_if);
            i_chk.check_reset_outputs();
        end
        close_test("reset outputs");

        ti = 0;
        while (ti < TRACE_LEN && trace_mem[ti][135:128] == 8'h01) begin
            send_config(trace_mem[ti][127:0]);
            ti++;
        end
        config_valid = 1'b0;
        @(negedge clk_if);
        close_test("sequence load");

        while (ti < TRACE_LEN && trace_mem[ti][135:128] == 8'h02) begin
            job_num++;
            run_job();
            close_test($sformatf("job %0d", job_num));
        end
        if (ti >= TRACE_LEN || trace_mem[ti][135:128] !== 8'hff) begin
            trace_bad = 1'b1;
            $display("Trace record %0d has an unknown tag", ti);
        end

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, i_chk.error_count);
        if (tests_failed == 0 && i_chk.error_count == 0 && !trace_bad) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verif/quad_trace.txt
// Tag 01 config word, 02 job (num_cols [20:12], seq_len [11:0], stall [32]),
// tag 03 pixel beat, 04 expected result, ff end; lane 7 leftmost
01_00010000_00030001_00020001_00000002
01_00030002_00010000_00000001_00020003
// Job 1, four columns, six entries, no stalls
02_00000000_00000000_00000000_00004006
03_A007A006_A005A004_A003A002_A001A000
03_A017A016_A015A014_A013A012_A011A010
03_A027A026_A025A024_A023A022_A021A020
03_A037A036_A035A034_A033A032_A031A030
04_A027A026_A025A024_A023A022_A021A020
04_A007A006_A005A004_A003A002_A001A000
04_A017A016_A015A014_A013A012_A011A010
04_A027A026_A025A024_A023A022_A021A020
04_A017A016_A015A014_A013A012_A011A010
04_A037A036_A035A034_A033A032_A031A030
// Job 1 again under random result stalls
02_00000000_00000000_00000001_00004006
03_A007A006_A005A004_A003A002_A001A000
03_A017A016_A015A014_A013A012_A011A010
03_A027A026_A025A024_A023A022_A021A020
03_A037A036_A035A034_A033A032_A031A030
04_A027A026_A025A024_A023A022_A021A020
04_A007A006_A005A004_A003A002_A001A000
04_A017A016_A015A014_A013A012_A011A010
04_A027A026_A025A024_A023A022_A021A020
04_A017A016_A015A014_A013A012_A011A010
04_A037A036_A035A034_A033A032_A031A030
// Job 2, new pixels, three columns, five entries
02_00000000_00000000_00000001_00003005
03_B007B006_B005B004_B003B002_B001B000
03_B017B016_B015B014_B013B012_B011B010
03_B027B026_B025B024_B023B022_B021B020
04_B027B026_B025B024_B023B022_B021B020
04_B007B006_B005B004_B003B002_B001B000
04_B017B016_B015B014_B013B012_B011B010
04_B027B026_B025B024_B023B022_B021B020
04_B017B016_B015B014_B013B012_B011B010
ff_00000000_00000000_00000000_00000000

// File: sources.f
hdl/quad_pkg.sv
hdl/pixel_seq_store.sv
hdl/prefetch_fifo.sv
hdl/quad_ctrl.sv
hdl/row_buffer.sv
hdl/cnn_quad_top.sv
verif/quad_checker.sv
verif/tb_quad.sv
